/* quad_ctrl_cfg_pkg.sv */
`default_nettype none

package quad_ctrl_cfg_pkg;

    // Default array and buffer sizes
    localparam int DEF_BRAM_DEPTH = 1024;
    localparam int DEF_NUM_AWE    = 4;
    localparam int DEF_CE_PER_AWE = 2;

    // Sequence memory words per output pixel
    localparam int SEQ_LEN     = 5;
    // Cycles from a sequence read to its compute launch
    localparam int SEQ_LATENCY = 3;
    // Input rows held before the first output row
    localparam int PRIME_ROWS  = 3;

    localparam int DIM_W      = $clog2(DEF_BRAM_DEPTH) - 1;
    localparam int SEQ_ADDR_W = 3;

    // Row or column index of the padded input map
    typedef logic [DIM_W-1:0] dim_t;
    typedef logic [SEQ_ADDR_W-1:0] seq_addr_t;

endpackage

`default_nettype wire

/* quad_ctrl_fsm_pkg.sv */
`default_nettype none

package quad_ctrl_fsm_pkg;

    // Layer sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRIME,
        ST_WAIT_FETCH,
        ST_RUN_ROW,
        ST_LOAD_ROW,
        ST_DONE
    } seq_state_e;

    // Row buffer select in Gray order 00 01 11 10
    typedef logic [1:0] row_sel_t;

endpackage

`default_nettype wire

/* exec_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface exec_if;

    // Start of one output row
    logic row_go;
    // One pulse per compute launch
    logic exec_beat;
    // Output row finished for one cycle
    logic row_end;
    // High while the current output row is the final one
    logic last_row;

    modport sequencer (
        output row_go,
        input  row_end,
        input  last_row
    );

    modport pipeline (
        input  row_go,
        output exec_beat
    );

    modport tracker (
        input  exec_beat,
        output row_end,
        output last_row
    );

endinterface

`default_nettype wire

/* job_port.sv */
`timescale 1ns/1ps
`default_nettype none

module job_port #(
    parameter int bram_depth = 1024
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           job_req,
    input  wire quad_ctrl_cfg_pkg::dim_t  num_cols,
    input  wire quad_ctrl_cfg_pkg::dim_t  num_rows,
    input  wire                           done_ack,
    input  wire                           job_end,
    output logic                          job_ack,
    output logic                          done_req,
    output logic                          job_go,
    output quad_ctrl_cfg_pkg::dim_t       cols,
    output quad_ctrl_cfg_pkg::dim_t       rows
);

    typedef enum logic [2:0] {
        JP_IDLE,
        JP_ACK,
        JP_BUSY,
        JP_DONE,
        JP_DONE_WAIT
    } port_state_e;

    port_state_e state;

    // Dimension ports are sized from the buffer depth
    if ($bits(quad_ctrl_cfg_pkg::dim_t) != $clog2(bram_depth) - 1) begin : g_depth_check
        $error("bram_depth does not match the dimension width");
    end

    //////////////////////////////////////////////////////////////////////
    // Host handshakes
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= JP_IDLE;
            job_ack  <= 1'b0;
            done_req <= 1'b0;
            job_go   <= 1'b0;
        end else begin
            job_go <= 1'b0;
            case (state)
                JP_IDLE: begin
                    if (job_req) begin
                        job_ack <= 1'b1;
                        state   <= JP_ACK;
                    end
                end
                JP_ACK: begin
                    // Job starts once the host has released req
                    if (!job_req) begin
                        job_ack <= 1'b0;
                        job_go  <= 1'b1;
                        state   <= JP_BUSY;
                    end
                end
                JP_BUSY: begin
                    if (job_end) begin
                        done_req <= 1'b1;
                        state    <= JP_DONE;
                    end
                end
                JP_DONE: begin
                    if (done_ack) begin
                        done_req <= 1'b0;
                        state    <= JP_DONE_WAIT;
                    end
                end
                JP_DONE_WAIT: begin
                    if (!done_ack) begin
                        state <= JP_IDLE;
                    end
                end
                default: state <= JP_IDLE;
            endcase
        end
    end

    // Dimensions captured as ack goes up
    always_ff @(posedge clk) begin
        if (state == JP_IDLE && job_req) begin
            cols <= num_cols;
            rows <= num_rows;
        end
    end

    a_no_job_during_done: assert property (@(posedge clk) disable iff (rst)
        done_req |-> !job_req);

endmodule

`default_nettype wire

/* layer_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module layer_sequencer #(
    parameter int num_awe    = 4,
    parameter int ce_per_awe = 2
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                job_go,
    input  wire quad_ctrl_cfg_pkg::dim_t       cols,
    input  wire quad_ctrl_cfg_pkg::dim_t       rows,
    input  wire                                fetch_ack,
    input  wire [num_awe*ce_per_awe-1:0]       ce_execute,
    output logic                               job_end,
    output logic                               fetch_req,
    output logic                               pfb_rden,
    output quad_ctrl_cfg_pkg::dim_t            buf_wr_addr,
    output quad_ctrl_fsm_pkg::row_sel_t        row_sel,
    exec_if.sequencer                          ex
);

    localparam int CNT_W = $bits(quad_ctrl_cfg_pkg::dim_t) + 1;
    localparam logic [1:0] PRIME_LAST = 2'(quad_ctrl_cfg_pkg::PRIME_ROWS - 1);

    quad_ctrl_fsm_pkg::seq_state_e state;
    logic [CNT_W-1:0] pf_count;
    logic [1:0]       prime_cnt;
    logic             priming;
    logic             fetch_acked;
    logic             row_over;
    logic             final_row;
    logic             reading;

    assign job_end = (state == quad_ctrl_fsm_pkg::ST_DONE);
    assign reading = (state == quad_ctrl_fsm_pkg::ST_PRIME) ||
                     (state == quad_ctrl_fsm_pkg::ST_LOAD_ROW);

    //////////////////////////////////////////////////////////////////////
    // Main sequencer FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= quad_ctrl_fsm_pkg::ST_IDLE;
            fetch_req   <= 1'b0;
            fetch_acked <= 1'b0;
            pfb_rden    <= 1'b0;
            pf_count    <= '0;
            prime_cnt   <= '0;
            priming     <= 1'b0;
            row_over    <= 1'b0;
            final_row   <= 1'b0;
            row_sel     <= '0;
            ex.row_go   <= 1'b0;
        end else begin
            pfb_rden  <= 1'b0;
            ex.row_go <= 1'b0;
            case (state)
                quad_ctrl_fsm_pkg::ST_IDLE: begin
                    if (job_go) begin
                        prime_cnt <= '0;
                        priming   <= 1'b1;
                        row_sel   <= '0;
                        state     <= quad_ctrl_fsm_pkg::ST_WAIT_FETCH;
                    end
                end
                quad_ctrl_fsm_pkg::ST_WAIT_FETCH: begin
                    // Four-phase fetch where req only rises with ack low
                    if (!fetch_acked) begin
                        if (fetch_req && fetch_ack) begin
                            fetch_req   <= 1'b0;
                            fetch_acked <= 1'b1;
                            pf_count    <= {1'b0, cols} + 1'b1;
                        end else if (!fetch_ack) begin
                            fetch_req <= 1'b1;
                        end
                    end else if (!fetch_ack) begin
                        fetch_acked <= 1'b0;
                        state <= priming ? quad_ctrl_fsm_pkg::ST_PRIME
                                         : quad_ctrl_fsm_pkg::ST_LOAD_ROW;
                    end
                end
                quad_ctrl_fsm_pkg::ST_PRIME, quad_ctrl_fsm_pkg::ST_LOAD_ROW: begin
                    if (pf_count != '0) begin
                        pfb_rden <= 1'b1;
                        pf_count <= pf_count - 1'b1;
                    end else if (priming && prime_cnt != PRIME_LAST) begin
                        prime_cnt <= prime_cnt + 1'b1;
                        state     <= quad_ctrl_fsm_pkg::ST_WAIT_FETCH;
                    end else begin
                        // Next Gray step only for rows loaded between output rows
                        if (!priming) begin
                            row_sel <= {row_sel[0], ~row_sel[1]};
                        end
                        priming   <= 1'b0;
                        ex.row_go <= 1'b1;
                        state     <= quad_ctrl_fsm_pkg::ST_RUN_ROW;
                    end
                end
                quad_ctrl_fsm_pkg::ST_RUN_ROW: begin
                    if (ex.row_end) begin
                        row_over  <= 1'b1;
                        final_row <= ex.last_row;
                    end else if (row_over && ce_execute == '0) begin
                        // Chain drained
                        row_over <= 1'b0;
                        state <= final_row ? quad_ctrl_fsm_pkg::ST_DONE
                                           : quad_ctrl_fsm_pkg::ST_WAIT_FETCH;
                    end
                end
                quad_ctrl_fsm_pkg::ST_DONE: state <= quad_ctrl_fsm_pkg::ST_IDLE;
                default: state <= quad_ctrl_fsm_pkg::ST_IDLE;
            endcase
        end
    end

    // Write address follows the column being streamed
    always_ff @(posedge clk) begin
        if (reading && pf_count != '0) begin
            buf_wr_addr <= quad_ctrl_cfg_pkg::dim_t'({1'b0, cols} + 1'b1 - pf_count);
        end
    end

    a_fetch_rise: assert property (@(posedge clk) disable iff (rst)
        !fetch_req && fetch_ack |=> !fetch_req);

    a_rden_no_fetch: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> !fetch_req && !fetch_ack);

    // A job needs at least one output row
    a_rows_valid: assert property (@(posedge clk) disable iff (rst)
        job_go |=> rows >= 2);

endmodule

`default_nettype wire

/* exec_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_pipeline #(
    parameter int num_awe    = 4,
    parameter int ce_per_awe = 2
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire quad_ctrl_cfg_pkg::dim_t     cols,
    output logic                             seq_rden,
    output quad_ctrl_cfg_pkg::seq_addr_t     seq_addr,
    output logic [num_awe*ce_per_awe-1:0]    ce_execute,
    exec_if.pipeline                         ex
);

    localparam int CHAIN_LEN = num_awe * ce_per_awe;
    localparam int DLY_LEN   = quad_ctrl_cfg_pkg::SEQ_LATENCY - 1;
    localparam quad_ctrl_cfg_pkg::seq_addr_t SEQ_LAST =
        quad_ctrl_cfg_pkg::seq_addr_t'(quad_ctrl_cfg_pkg::SEQ_LEN - 1);

    // Pixels still to read after the current one
    quad_ctrl_cfg_pkg::dim_t pix_left;
    logic [DLY_LEN-1:0]      rd_dly;

    //////////////////////////////////////////////////////////////////////
    // Sequence memory reads
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_rden <= 1'b0;
            seq_addr <= '0;
            pix_left <= '0;
        end else if (ex.row_go) begin
            seq_rden <= 1'b1;
            seq_addr <= '0;
            pix_left <= cols;
        end else if (seq_rden) begin
            if (seq_addr == SEQ_LAST) begin
                seq_addr <= '0;
                if (pix_left == '0) begin
                    seq_rden <= 1'b0;
                end else begin
                    pix_left <= pix_left - 1'b1;
                end
            end else begin
                seq_addr <= seq_addr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read latency and enable chain
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_dly     <= '0;
            ce_execute <= '0;
        end else begin
            rd_dly     <= {rd_dly[DLY_LEN-2:0], seq_rden};
            ce_execute <= {ce_execute[CHAIN_LEN-2:0], rd_dly[DLY_LEN-1]};
        end
    end

    // Launch beat lines up with chain position 0
    assign ex.exec_beat = ce_execute[0];

    a_no_overlap_row: assert property (@(posedge clk) disable iff (rst)
        ex.row_go |-> !seq_rden);

endmodule

`default_nettype wire

/* output_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module output_tracker (
    input  wire                           clk,
    input  wire                           rst,
    input  wire quad_ctrl_cfg_pkg::dim_t  cols,
    input  wire quad_ctrl_cfg_pkg::dim_t  rows,
    input  wire                           job_go,
    exec_if.tracker                       ex
);

    localparam quad_ctrl_cfg_pkg::seq_addr_t WORD_LAST =
        quad_ctrl_cfg_pkg::seq_addr_t'(quad_ctrl_cfg_pkg::SEQ_LEN - 1);

    quad_ctrl_cfg_pkg::seq_addr_t word_cnt;
    quad_ctrl_cfg_pkg::dim_t      out_col;
    quad_ctrl_cfg_pkg::dim_t      out_row;

    // R input rows give R-1 output rows, numbered 0 to R-2
    assign ex.last_row = (out_row == quad_ctrl_cfg_pkg::dim_t'(rows - 2'd2));

    always_ff @(posedge clk) begin
        if (rst) begin
            word_cnt   <= '0;
            out_col    <= '0;
            out_row    <= '0;
            ex.row_end <= 1'b0;
        end else begin
            ex.row_end <= 1'b0;
            if (job_go) begin
                word_cnt <= '0;
                out_col  <= '0;
                out_row  <= '0;
            end else begin
                // Row index moves after row_end so last_row holds through it
                if (ex.row_end) begin
                    out_row <= out_row + 1'b1;
                end
                if (ex.exec_beat) begin
                    if (word_cnt == WORD_LAST) begin
                        word_cnt <= '0;
                        if (out_col == cols) begin
                            out_col    <= '0;
                            ex.row_end <= 1'b1;
                        end else begin
                            out_col <= out_col + 1'b1;
                        end
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* quad_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module quad_ctrl_top #(
    parameter int bram_depth = quad_ctrl_cfg_pkg::DEF_BRAM_DEPTH,
    parameter int num_awe    = quad_ctrl_cfg_pkg::DEF_NUM_AWE,
    parameter int ce_per_awe = quad_ctrl_cfg_pkg::DEF_CE_PER_AWE
) (
    input  wire                              clk,
    input  wire                              rst,
    // Host job and done handshakes
    input  wire                              job_req,
    output logic                             job_ack,
    input  wire quad_ctrl_cfg_pkg::dim_t     num_cols,
    input  wire quad_ctrl_cfg_pkg::dim_t     num_rows,
    output logic                             done_req,
    input  wire                              done_ack,
    // Loader fetch handshake
    output logic                             fetch_req,
    input  wire                              fetch_ack,
    // Prefetch buffer
    output logic                             pfb_rden,
    output quad_ctrl_cfg_pkg::dim_t          buf_wr_addr,
    output quad_ctrl_fsm_pkg::row_sel_t      row_sel,
    // Sequence memory and compute elements
    output logic                             seq_rden,
    output quad_ctrl_cfg_pkg::seq_addr_t     seq_addr,
    output logic [num_awe*ce_per_awe-1:0]    ce_execute
);

    logic                    job_go;
    logic                    job_end;
    quad_ctrl_cfg_pkg::dim_t cols;
    quad_ctrl_cfg_pkg::dim_t rows;

    exec_if ex_if ();

    job_port #(
        .bram_depth (bram_depth)
    ) job_port_i (
        .clk      (clk),
        .rst      (rst),
        .job_req  (job_req),
        .num_cols (num_cols),
        .num_rows (num_rows),
        .done_ack (done_ack),
        .job_end  (job_end),
        .job_ack  (job_ack),
        .done_req (done_req),
        .job_go   (job_go),
        .cols     (cols),
        .rows     (rows)
    );

    layer_sequencer #(
        .num_awe    (num_awe),
        .ce_per_awe (ce_per_awe)
    ) layer_sequencer_i (
        .clk         (clk),
        .rst         (rst),
        .job_go      (job_go),
        .cols        (cols),
        .rows        (rows),
        .fetch_ack   (fetch_ack),
        .ce_execute  (ce_execute),
        .job_end     (job_end),
        .fetch_req   (fetch_req),
        .pfb_rden    (pfb_rden),
        .buf_wr_addr (buf_wr_addr),
        .row_sel     (row_sel),
        .ex          (ex_if.sequencer)
    );

    exec_pipeline #(
        .num_awe    (num_awe),
        .ce_per_awe (ce_per_awe)
    ) exec_pipeline_i (
        .clk        (clk),
        .rst        (rst),
        .cols       (cols),
        .seq_rden   (seq_rden),
        .seq_addr   (seq_addr),
        .ce_execute (ce_execute),
        .ex         (ex_if.pipeline)
    );

    output_tracker output_tracker_i (
        .clk    (clk),
        .rst    (rst),
        .cols   (cols),
        .rows   (rows),
        .job_go (job_go),
        .ex     (ex_if.tracker)
    );

endmodule

`default_nettype wire

/* tb_quad_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_quad_ctrl;

    localparam int CHAIN_LEN = quad_ctrl_cfg_pkg::DEF_NUM_AWE * quad_ctrl_cfg_pkg::DEF_CE_PER_AWE;
    localparam int SEQ_LEN   = quad_ctrl_cfg_pkg::SEQ_LEN;
    localparam int LAT       = quad_ctrl_cfg_pkg::SEQ_LATENCY;
    localparam quad_ctrl_cfg_pkg::seq_addr_t ADDR_LAST =
        quad_ctrl_cfg_pkg::seq_addr_t'(SEQ_LEN - 1);

    logic clk = 1'b0;
    logic rst;
    logic job_req, job_ack, done_req, done_ack, fetch_req, fetch_ack;
    logic pfb_rden, seq_rden;
    quad_ctrl_cfg_pkg::dim_t num_cols, num_rows, buf_wr_addr;
    quad_ctrl_fsm_pkg::row_sel_t row_sel;
    quad_ctrl_cfg_pkg::seq_addr_t seq_addr;
    logic [CHAIN_LEN-1:0] ce_execute;

    // Reference state, all sampled on the rising edge
    logic rst_d = 1'b0;
    logic [LAT-1:0] rden_hist = '0;
    logic [CHAIN_LEN-1:0] ce_prev;
    quad_ctrl_fsm_pkg::row_sel_t sel_prev, sel_expect;
    logic ack_prev, job_start_d, req_prev, done_prev;
    quad_ctrl_cfg_pkg::dim_t rd_col, cur_c;
    quad_ctrl_cfg_pkg::seq_addr_t exp_seq_addr;
    logic [CHAIN_LEN+6:0] reset_view;
    int fetch_cnt = 0, rden_cnt = 0, seq_cnt = 0, ce0_cnt = 0, sel_cnt = 0, done_cnt = 0;
    int assert_errors = 0, count_errors = 0;
    int cycle_count = 0, cycle_limit = 0;
    logic [31:0] lfsr_state = 32'd84422;
    string job_name = "reset";

    always #2 clk = ~clk;

    quad_ctrl_top dut_i (
        .clk (clk), .rst (rst),
        .job_req (job_req), .job_ack (job_ack), .num_cols (num_cols), .num_rows (num_rows),
        .done_req (done_req), .done_ack (done_ack),
        .fetch_req (fetch_req), .fetch_ack (fetch_ack),
        .pfb_rden (pfb_rden), .buf_wr_addr (buf_wr_addr), .row_sel (row_sel),
        .seq_rden (seq_rden), .seq_addr (seq_addr), .ce_execute (ce_execute)
    );

    assign reset_view = {job_ack, done_req, fetch_req, pfb_rden, seq_rden, ce_execute, row_sel};
    assign sel_expect = job_start_d ? 2'b00 : gray_next(sel_prev);

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hD000_0001) : (lfsr_state >> 1);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    // Row buffer order 00 01 11 10
    function automatic quad_ctrl_fsm_pkg::row_sel_t gray_next(
        input quad_ctrl_fsm_pkg::row_sel_t s
    );
        case (s)
            2'b00: return 2'b01;
            2'b01: return 2'b11;
            2'b11: return 2'b10;
            default: return 2'b00;
        endcase
    endfunction

    function automatic int job_cycles(input int c, input int r);
        return (c + 1) * (r + 1) * SEQ_LEN;
    endfunction

    task automatic log_mismatch(input string check, input int expected, input int actual);
        $display("Error %s %s: expected %0d actual %0d", job_name, check, expected, actual);
        assert_errors++;
    endtask

    task automatic log_failure(input string what);
        $display("Failure in %s: %s", job_name, what);
        assert_errors++;
    endtask

    task automatic compare_count(input string check, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Error %s %s: expected %0d actual %0d", job_name, check, expected, actual);
            count_errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference tracking and event counters
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        rst_d       <= rst;
        rden_hist   <= {rden_hist[LAT-2:0], seq_rden};
        ce_prev     <= ce_execute;
        sel_prev    <= row_sel;
        ack_prev    <= job_ack;
        job_start_d <= ack_prev && !job_ack;
        req_prev    <= fetch_req;
        done_prev   <= done_req;
        if (rst) begin
            rd_col       <= '0;
            exp_seq_addr <= '0;
        end else begin
            if (fetch_req && fetch_ack)
                rd_col <= '0;
            else if (pfb_rden)
                rd_col <= rd_col + 1'b1;
            if (seq_rden)
                exp_seq_addr <= (exp_seq_addr == ADDR_LAST) ? '0 : exp_seq_addr + 1'b1;
            fetch_cnt <= fetch_cnt + int'(fetch_req && !req_prev);
            rden_cnt  <= rden_cnt + int'(pfb_rden);
            seq_cnt   <= seq_cnt + int'(seq_rden);
            ce0_cnt   <= ce0_cnt + int'(ce_execute[0]);
            sel_cnt   <= sel_cnt + int'(row_sel != sel_prev && !job_start_d);
            done_cnt  <= done_cnt + int'(done_req && !done_prev);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Concurrent checks
    //////////////////////////////////////////////////////////////////////
    a_reset: assert property (@(posedge clk) rst_d |-> reset_view == '0)
        else log_mismatch("reset_outputs", 0, int'($sampled(reset_view)));
    a_ack_rise: assert property (@(posedge clk) disable iff (rst) $rose(job_req) |=> job_ack)
        else log_mismatch("job_ack_rise", 1, int'($sampled(job_ack)));
    a_ack_fall: assert property (@(posedge clk) disable iff (rst) $fell(job_req) |=> !job_ack)
        else log_mismatch("job_ack_fall", 0, int'($sampled(job_ack)));
    a_done_hold: assert property (@(posedge clk) disable iff (rst)
        done_req && !done_ack |=> done_req)
        else log_mismatch("done_req_hold", 1, int'($sampled(done_req)));
    a_done_fall: assert property (@(posedge clk) disable iff (rst)
        done_req && done_ack |=> !done_req)
        else log_mismatch("done_req_fall", 0, int'($sampled(done_req)));
    a_rden_idle: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> !fetch_req && !fetch_ack)
        else log_failure("buffer read while the fetch handshake was active");
    a_wr_addr: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> buf_wr_addr == rd_col)
        else log_mismatch("buf_wr_addr", int'($sampled(rd_col)), int'($sampled(buf_wr_addr)));
    a_row_len: assert property (@(posedge clk) disable iff (rst) pfb_rden |-> rd_col <= cur_c)
        else log_failure("more than C+1 buffer reads after one fetch");
    a_seq_addr: assert property (@(posedge clk) disable iff (rst)
        seq_rden |-> seq_addr == exp_seq_addr)
        else log_mismatch("seq_addr", int'($sampled(exp_seq_addr)), int'($sampled(seq_addr)));
    a_ce_launch: assert property (@(posedge clk) disable iff (rst)
        ce_execute[0] == rden_hist[LAT-1])
        else log_mismatch("ce_launch", int'($sampled(rden_hist[LAT-1])),
                          int'($sampled(ce_execute[0])));
    a_ce_chain: assert property (@(posedge clk) disable iff (rst)
        ce_execute[CHAIN_LEN-1:1] == ce_prev[CHAIN_LEN-2:0])
        else log_mismatch("ce_chain", int'($sampled(ce_prev[CHAIN_LEN-2:0])),
                          int'($sampled(ce_execute[CHAIN_LEN-1:1])));
    a_row_sel: assert property (@(posedge clk) disable iff (rst)
        row_sel != sel_prev |-> row_sel == sel_expect)
        else log_mismatch("row_sel", int'($sampled(sel_expect)), int'($sampled(row_sel)));

    //////////////////////////////////////////////////////////////////////
    // Loader, host and run control
    //////////////////////////////////////////////////////////////////////
    initial begin : loader_model
        int delay;
        fetch_ack = 1'b0;
        forever begin
            next_cycle();
            if (fetch_req && !fetch_ack) begin
                delay = draw_bits(3);
                repeat (delay) next_cycle();
                fetch_ack = 1'b1;
                while (fetch_req) next_cycle();
                fetch_ack = 1'b0;
            end
        end
    end

    task automatic run_job(input string name, input int c, input int r);
        int b_fetch, b_rden, b_seq, b_ce0, b_sel, b_done;
        int delay;
        job_name = name;
        cur_c    = quad_ctrl_cfg_pkg::dim_t'(c);
        b_fetch  = fetch_cnt;
        b_rden   = rden_cnt;
        b_seq    = seq_cnt;
        b_ce0    = ce0_cnt;
        b_sel    = sel_cnt;
        b_done   = done_cnt;
        num_cols = quad_ctrl_cfg_pkg::dim_t'(c);
        num_rows = quad_ctrl_cfg_pkg::dim_t'(r);
        job_req  = 1'b1;
        while (!job_ack) next_cycle();
        job_req = 1'b0;
        while (job_ack) next_cycle();
        while (!done_req) next_cycle();
        delay = draw_bits(3);
        repeat (delay) next_cycle();
        done_ack = 1'b1;
        while (done_req) next_cycle();
        done_ack = 1'b0;
        repeat (4) next_cycle();
        compare_count("fetches", r + 1, fetch_cnt - b_fetch);
        compare_count("buffer_reads", (r + 1) * (c + 1), rden_cnt - b_rden);
        compare_count("seq_reads", SEQ_LEN * (c + 1) * (r - 1), seq_cnt - b_seq);
        compare_count("ce_launches", SEQ_LEN * (c + 1) * (r - 1), ce0_cnt - b_ce0);
        compare_count("row_sel_steps", r - 2, sel_cnt - b_sel);
        compare_count("done_requests", 1, done_cnt - b_done);
    endtask

    // Run ends here if the DUT stalls
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: no result after %0d cycles", cycle_limit);
            $display("Errors: %0d assertion, %0d count", assert_errors, count_errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin : main_sequence
        int c3, r3;
        rst      = 1'b1;
        job_req  = 1'b0;
        done_ack = 1'b0;
        num_cols = '0;
        num_rows = '0;
        c3 = draw_bits(3);
        r3 = 2 + draw_bits(3) % 5;
        cycle_limit = 40 * (job_cycles(3, 3) + job_cycles(5, 4) + job_cycles(c3, r3)) + 2000;
        repeat (10) next_cycle();
        rst = 1'b0;
        repeat (3) next_cycle();
        run_job("job1", 3, 3);
        run_job("job2", 5, 4);
        run_job("job3", c3, r3);
        $display("Errors: %0d assertion, %0d count", assert_errors, count_errors);
        if (assert_errors == 0 && count_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
quad_ctrl_cfg_pkg.sv
quad_ctrl_fsm_pkg.sv
exec_if.sv
job_port.sv
layer_sequencer.sv
exec_pipeline.sv
output_tracker.sv
quad_ctrl_top.sv
tb_quad_ctrl.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run tb_quad_ctrl, check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_quad_ctrl -f src.f -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
